/* design/tile_pkg.sv */
package tile_pkg;

    // raster geometry, counts of pixel clock enables
    localparam int h_total   = 256;  // full line
    localparam int h_visible = 192;  // active pixels per line
    localparam int v_total   = 192;  // full frame
    localparam int v_visible = 160;  // active lines per frame

    // tile and map layout
    localparam int tile_bits     = 3;  // 8x8 tiles
    localparam int map_cols_bits = 5;  // 32 columns
    localparam int map_rows_bits = 5;  // 32 rows
    localparam int vram_depth    = 1024;

    localparam int rom_file_words = 32;  // 4 codes x 8 rows in tiles.hex

    // raster position
    typedef logic [7:0] hpos_t;
    typedef logic [7:0] vpos_t;

    // vram word index, row on top of column
    typedef logic [map_rows_bits+map_cols_bits-1:0] vram_addr_t;

    typedef logic [7:0] code_t;
    typedef logic [3:0] pal_t;

    // code[13:6] pal[5:2] hflip[1] vflip[0]
    typedef logic [13:0] tile_attr_t;

    typedef logic [10:0] rom_addr_t;  // code then row
    typedef logic [31:0] rom_word_t;  // one byte per plane, byte 3 is the colour msb
    typedef logic [7:0]  pixel_t;     // palette and colour

    typedef logic [12:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t ctrl_addr = 13'h1000;  // flip register, bit 0

    typedef enum logic [1:0] {
        st_idle,       // waiting for a setup cycle
        st_access,     // first access cycle
        st_read_wait,  // vram read latency
        st_done        // transfer finished, wait for penable low
    } apb_state_t;

endpackage

/* design/video_timer.sv */
module video_timer (
    input  logic            clk,
    input  logic            rst,
    output logic            pxl_cen,
    output tile_pkg::hpos_t hdump,
    output tile_pkg::vpos_t vdump,
    output logic            blankn
);

    logic            h_wrap;
    logic            v_wrap;
    tile_pkg::hpos_t h_next;
    tile_pkg::vpos_t v_next;

    // pixel clock is half of clk
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    assign h_wrap = hdump == tile_pkg::hpos_t'(tile_pkg::h_total - 1);
    assign v_wrap = vdump == tile_pkg::vpos_t'(tile_pkg::v_total - 1);

    // position after the coming enable
    assign h_next = h_wrap ? '0 : hdump + 1'b1;
    always_comb begin
        v_next = vdump;
        if (h_wrap) begin
            v_next = v_wrap ? '0 : vdump + 1'b1;  // new line
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hdump  <= '0;
            vdump  <= '0;
            blankn <= 1'b1;  // 0,0 is inside the active area
        end else if (pxl_cen) begin
            hdump  <= h_next;
            vdump  <= v_next;
            // blanking from the next position keeps it aligned with the counters
            blankn <= (h_next < tile_pkg::hpos_t'(tile_pkg::h_visible)) &&
                      (v_next < tile_pkg::vpos_t'(tile_pkg::v_visible));
        end
    end

    // the raster only moves on the pixel clock
    hdump_on_cen_a: assert property (
        @(posedge clk) disable iff (rst)
        !$stable(hdump) |-> $past(pxl_cen)
    ) else $error("hdump moved without pxl_cen");

endmodule

/* design/apb_tile_ctrl.sv */
module apb_tile_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  tile_pkg::apb_addr_t    paddr,
    input  tile_pkg::apb_data_t    pwdata,
    output tile_pkg::apb_data_t    prdata,
    output logic                   pready,
    output logic                   pslverr,
    output tile_pkg::vram_addr_t   cpu_addr,
    output tile_pkg::tile_attr_t   cpu_wdata,
    output logic                   cpu_we,
    input  tile_pkg::tile_attr_t   cpu_rdata,
    output logic                   flip
);

    tile_pkg::apb_state_t state;

    logic is_vram;   // word addressed tile ram
    logic is_ctrl;   // flip register
    logic is_err;    // unmapped
    logic in_access; // first access cycle of a transfer
    logic vram_rd;

    // decode on the word address
    assign is_vram   = ~paddr[12];
    assign is_ctrl   = paddr[12:2] == tile_pkg::ctrl_addr[12:2];
    assign is_err    = ~is_vram & ~is_ctrl;
    assign in_access = (state == tile_pkg::st_access) && psel && penable;
    assign vram_rd   = is_vram & ~pwrite;

    // vram side follows the bus directly
    assign cpu_addr  = paddr[2 +: $bits(tile_pkg::vram_addr_t)];
    assign cpu_wdata = pwdata[$bits(tile_pkg::tile_attr_t)-1:0];
    assign cpu_we    = in_access & pwrite & is_vram;  // one clk pulse

    // vram reads need one more cycle for the registered ram port
    assign pready  = (in_access & ~vram_rd) || (state == tile_pkg::st_read_wait);
    assign pslverr = in_access & is_err;

    always_comb begin
        prdata = '0;
        case (state)
            tile_pkg::st_access: begin
                if (is_ctrl) begin
                    prdata = tile_pkg::apb_data_t'(flip);
                end
            end
            tile_pkg::st_read_wait: prdata = tile_pkg::apb_data_t'(cpu_rdata);  // upper bits zero
            default: prdata = '0;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= tile_pkg::st_idle;
            flip  <= 1'b0;
        end else begin
            case (state)
                tile_pkg::st_idle: begin
                    if (psel && !penable) begin
                        state <= tile_pkg::st_access;  // setup seen
                    end
                end
                tile_pkg::st_access: begin
                    if (psel && penable) begin
                        if (pwrite && is_ctrl) begin
                            flip <= pwdata[0];
                        end
                        state <= vram_rd ? tile_pkg::st_read_wait : tile_pkg::st_done;
                    end
                end
                tile_pkg::st_read_wait: state <= tile_pkg::st_done;  // data out this cycle
                tile_pkg::st_done: begin
                    // back to back transfers go straight to the next access
                    if (!penable) begin
                        state <= psel ? tile_pkg::st_access : tile_pkg::st_idle;
                    end
                end
                default: state <= tile_pkg::st_idle;
            endcase
        end
    end

    // host side protocol
    penable_needs_psel_a: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> psel
    ) else $error("penable without psel");

    slverr_with_ready_a: assert property (
        @(posedge clk) disable iff (rst)
        pslverr |-> pready
    ) else $error("pslverr outside of pready");

endmodule

/* design/tile_vram.sv */
module tile_vram (
    input  logic                 clk,
    // host port
    input  tile_pkg::vram_addr_t cpu_addr,
    input  tile_pkg::tile_attr_t cpu_wdata,
    input  logic                 cpu_we,
    output tile_pkg::tile_attr_t cpu_rdata,
    // video port, read only
    input  tile_pkg::vram_addr_t vram_addr,
    output tile_pkg::tile_attr_t vram_attr
);

    tile_pkg::tile_attr_t mem [tile_pkg::vram_depth];

    // host port, read returns the old word on a write
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_wdata;
        end
        cpu_rdata <= mem[cpu_addr];
    end

    // video port
    always_ff @(posedge clk) begin
        vram_attr <= mem[vram_addr];  // one clk latency
    end

endmodule

/* design/tile_rom.sv */
module tile_rom (
    input  logic                clk,
    input  logic                rom_cs,
    input  tile_pkg::rom_addr_t rom_addr,
    output tile_pkg::rom_word_t rom_data
);

    localparam int rom_depth = 2 ** $bits(tile_pkg::rom_addr_t);

    tile_pkg::rom_word_t mem [rom_depth];

    // unused codes read as transparent
    initial begin
        for (int i = 0; i < rom_depth; i++) begin
            mem[i] = '0;
        end
        $readmemh("tiles.hex", mem, 0, tile_pkg::rom_file_words - 1);
    end

    always_ff @(posedge clk) begin
        if (rom_cs) begin
            rom_data <= mem[rom_addr];  // held while not selected
        end
    end

endmodule

/* design/tilemap_gen.sv */
module tilemap_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  tile_pkg::hpos_t      hdump,
    input  tile_pkg::vpos_t      vdump,
    input  logic                 blankn,   // no rom requests while blank
    input  logic                 flip,     // global screen flip
    output tile_pkg::vram_addr_t vram_addr,
    input  tile_pkg::tile_attr_t vram_attr,
    output tile_pkg::rom_addr_t  rom_addr,
    output logic                 rom_cs,
    input  tile_pkg::rom_word_t  rom_data,
    output tile_pkg::pixel_t     pxl
);

    localparam int tb = tile_pkg::tile_bits;

    logic               tile_end;  // last pixel count of a tile
    tile_pkg::code_t    code;
    tile_pkg::pal_t     pal;
    logic               vf_eff;
    logic               hf_eff;

    tile_pkg::pal_t     req_pal;   // travels with the rom request
    logic               req_hf;
    tile_pkg::pal_t     cur_pal;   // tile being shifted out
    logic               cur_hf;
    tile_pkg::rom_word_t shift_q;

    // map entry under the beam
    assign vram_addr = {vdump[tb +: tile_pkg::map_rows_bits],
                        hdump[tb +: tile_pkg::map_cols_bits]};

    // boundary taken one count early so the load lands on pixel 0 of the next tile
    assign tile_end = &hdump[tb-1:0];

    assign code   = vram_attr[13:6];
    assign pal    = vram_attr[5:2];
    assign hf_eff = flip ^ vram_attr[1];
    assign vf_eff = flip ^ vram_attr[0];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_cs   <= 1'b0;
            rom_addr <= '0;
            req_pal  <= '0;
            req_hf   <= 1'b0;
            cur_pal  <= '0;
            cur_hf   <= 1'b0;
            shift_q  <= '0;
        end else if (pxl_cen) begin
            if (tile_end) begin
                // request the current column
                rom_cs   <= blankn;
                rom_addr <= {code, vdump[tb-1:0] ^ {tb{vf_eff}}};
                req_pal  <= pal;
                req_hf   <= hf_eff;
                // and start showing the one requested a tile ago
                cur_pal  <= req_pal;
                cur_hf   <= req_hf;
                shift_q  <= rom_data;
            end else begin
                shift_q <= cur_hf ? shift_q >> 1 : shift_q << 1;
            end
        end
    end

    // one bit per plane from the edge being shifted out, plane 3 on top
    assign pxl = {cur_pal, cur_hf ? {shift_q[24], shift_q[16], shift_q[8], shift_q[0]}
                                  : {shift_q[31], shift_q[23], shift_q[15], shift_q[7]}};

    // a blank tile boundary keeps the rom idle until the next boundary
    rom_idle_in_blank_a: assert property (
        @(posedge clk) disable iff (rst)
        (pxl_cen && tile_end && !blankn) |=> (!rom_cs until (pxl_cen && tile_end))
    ) else $error("rom request during blanking");

endmodule

/* design/tile_layer.sv */
module tile_layer (
    input  logic                clk,
    input  logic                rst,
    // apb slave
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  tile_pkg::apb_addr_t paddr,
    input  tile_pkg::apb_data_t pwdata,
    output tile_pkg::apb_data_t prdata,
    output logic                pready,
    output logic                pslverr,
    // video
    output logic                pxl_cen,
    output tile_pkg::hpos_t     hdump,
    output tile_pkg::vpos_t     vdump,
    output logic                blankn,
    output tile_pkg::pixel_t    pxl
);

    tile_pkg::vram_addr_t cpu_addr;
    tile_pkg::tile_attr_t cpu_wdata;
    logic                 cpu_we;
    tile_pkg::tile_attr_t cpu_rdata;
    logic                 flip;

    tile_pkg::vram_addr_t vram_addr;
    tile_pkg::tile_attr_t vram_attr;
    tile_pkg::rom_addr_t  rom_addr;
    logic                 rom_cs;
    tile_pkg::rom_word_t  rom_data;

    video_timer timer_i (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .blankn  (blankn)
    );

    apb_tile_ctrl ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_we    (cpu_we),
        .cpu_rdata (cpu_rdata),
        .flip      (flip)
    );

    tile_vram vram_i (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_we    (cpu_we),
        .cpu_rdata (cpu_rdata),
        .vram_addr (vram_addr),
        .vram_attr (vram_attr)
    );

    tile_rom rom_i (
        .clk      (clk),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    tilemap_gen gen_i (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .hdump     (hdump),
        .vdump     (vdump),
        .blankn    (blankn),
        .flip      (flip),
        .vram_addr (vram_addr),
        .vram_attr (vram_attr),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .rom_data  (rom_data),
        .pxl       (pxl)
    );

endmodule

/* dv/tb_clock.sv */
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

endmodule

/* dv/tile_layer_tb.sv */
module tile_layer_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int tile_px      = 1 << tile_pkg::tile_bits;
    localparam int map_cols     = 1 << tile_pkg::map_cols_bits;
    localparam int lead_px      = 2 * tile_px;  // two tiles in flight
    localparam int timeout_clks = 350000;       // vram fill plus three frames

    logic                clk;
    logic                rst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    tile_pkg::apb_addr_t paddr;
    tile_pkg::apb_data_t pwdata;
    tile_pkg::apb_data_t prdata;
    logic                pready;
    logic                pslverr;
    logic                pxl_cen;
    tile_pkg::hpos_t     hdump;
    tile_pkg::vpos_t     vdump;
    logic                blankn;
    tile_pkg::pixel_t    pxl;

    tile_pkg::tile_attr_t shadow [tile_pkg::vram_depth];      // host copy of vram
    tile_pkg::rom_word_t  rom_ref [tile_pkg::rom_file_words];

    logic post_reset = 1'b0;  // quiet window after reset
    logic raster_chk = 1'b0;
    logic check_en   = 1'b0;  // one frame of pixel compare
    logic model_flip = 1'b0;
    logic ready_seen = 1'b0;  // a transfer completed on the last edge
    tile_pkg::apb_data_t exp_rdata = '0;
    int cycles = 0;

    // previous edge, for the raster rules
    tile_pkg::hpos_t prev_h = '0;
    tile_pkg::vpos_t prev_v = '0;
    logic prev_cen     = 1'b0;
    logic prev_penable = 1'b0;
    logic prev_pready  = 1'b0;

    logic             exp_cen;
    tile_pkg::hpos_t  exp_h;
    tile_pkg::vpos_t  exp_v;
    logic             exp_blankn;
    tile_pkg::pixel_t exp_pxl;

    tb_clock clock_i (.clk(clk));

    tile_layer dut_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .blankn  (blankn),
        .pxl     (pxl)
    );

    function automatic tile_pkg::hpos_t h_after(input tile_pkg::hpos_t h);
        return (int'(h) == tile_pkg::h_total - 1) ? '0 : h + 1'b1;
    endfunction

    function automatic tile_pkg::vpos_t v_after(input tile_pkg::vpos_t v);
        return (int'(v) == tile_pkg::v_total - 1) ? '0 : v + 1'b1;
    endfunction

    function automatic logic in_visible(input tile_pkg::hpos_t h, input tile_pkg::vpos_t v);
        return (int'(h) < tile_pkg::h_visible) && (int'(v) < tile_pkg::v_visible);
    endfunction

    function automatic logic addr_unmapped(input tile_pkg::apb_addr_t a);
        return a[12] && (a[11:2] != '0);  // above the control word
    endfunction

    // pixel shown at h,v is the map column two tiles to the left
    function automatic tile_pkg::pixel_t expect_pixel(input tile_pkg::hpos_t h,
                                                      input tile_pkg::vpos_t v,
                                                      input logic gflip);
        int col;
        int line;
        int bit_i;
        tile_pkg::tile_attr_t attr;
        tile_pkg::rom_word_t word;
        col   = ((int'(h) / tile_px) - 2) & (map_cols - 1);
        attr  = shadow[((int'(v) / tile_px) & 31) * map_cols + col];
        line  = int'(v) % tile_px;
        if (gflip ^ attr[0]) begin
            line = tile_px - 1 - line;  // vertical flip
        end
        word  = rom_ref[(int'(attr[13:6]) * tile_px + line) % tile_pkg::rom_file_words];
        bit_i = (gflip ^ attr[1]) ? int'(h) % tile_px : tile_px - 1 - int'(h) % tile_px;
        return {attr[5:2], word[24 + bit_i], word[16 + bit_i], word[8 + bit_i], word[bit_i]};
    endfunction

    function automatic tile_pkg::tile_attr_t random_attr();
        tile_pkg::code_t code;
        tile_pkg::pal_t  pal;
        logic [1:0]      flips;
        code  = tile_pkg::code_t'($urandom_range(3, 0));  // only codes in tiles.hex
        pal   = tile_pkg::pal_t'($urandom);
        flips = 2'($urandom);
        return {code, pal, flips};
    endfunction

    function automatic tile_pkg::apb_addr_t vram_offset(input int idx);
        return tile_pkg::apb_addr_t'(idx << 2);  // byte address of a word
    endfunction

    always @(posedge clk) begin
        prev_h       <= hdump;
        prev_v       <= vdump;
        prev_cen     <= pxl_cen;
        prev_penable <= penable;
        prev_pready  <= pready;
        ready_seen   <= psel && penable && pready;
        cycles       <= cycles + 1;
    end

    always_comb begin
        exp_cen    = ~prev_cen;
        exp_h      = prev_cen ? h_after(prev_h) : prev_h;
        exp_v      = (prev_cen && int'(prev_h) == tile_pkg::h_total - 1) ? v_after(prev_v)
                                                                          : prev_v;
        exp_blankn = in_visible(hdump, vdump);
        exp_pxl    = expect_pixel(hdump, vdump, model_flip);
    end

    task automatic stop_failed();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, want, $time);
        stop_failed();
    endtask

    always @(posedge clk) begin
        if (cycles >= timeout_clks) begin
            $display("timeout: the run did not finish within %0d clocks", timeout_clks);
            stop_failed();
        end
    end

    // setup, then access until pready
    task automatic transfer(input logic wr, input tile_pkg::apb_addr_t addr,
                            input tile_pkg::apb_data_t data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        do begin
            @(negedge clk);
        end while (!ready_seen);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_word(input tile_pkg::apb_addr_t addr, input tile_pkg::apb_data_t data);
        transfer(1'b1, addr, data);
    endtask

    task automatic read_word(input tile_pkg::apb_addr_t addr, input tile_pkg::apb_data_t want);
        exp_rdata = want;
        transfer(1'b0, addr, '0);
    endtask

    task automatic fill_vram();
        tile_pkg::tile_attr_t attr;
        for (int i = 0; i < tile_pkg::vram_depth; i++) begin
            attr      = random_attr();
            shadow[i] = attr;
            write_word(vram_offset(i), tile_pkg::apb_data_t'(attr));
        end
    endtask

    task automatic wait_frame_start();
        do begin
            @(negedge clk);
        end while (int'(vdump) != tile_pkg::v_total - 1);
        do begin
            @(negedge clk);
        end while (vdump != '0);
    endtask

    task automatic check_frame();
        wait_frame_start();
        check_en = 1'b1;
        do begin
            @(negedge clk);
        end while (int'(vdump) != tile_pkg::v_visible);  // all active lines seen
        check_en = 1'b0;
    endtask

    cen_toggle_a: assert property (@(posedge clk) disable iff (rst)
        raster_chk |-> pxl_cen == exp_cen
    ) else report_mismatch("pxl_cen", 32'($sampled(pxl_cen)), 32'($sampled(exp_cen)));

    hdump_step_a: assert property (@(posedge clk) disable iff (rst)
        raster_chk |-> hdump == exp_h
    ) else report_mismatch("hdump", 32'($sampled(hdump)), 32'($sampled(exp_h)));

    vdump_step_a: assert property (@(posedge clk) disable iff (rst)
        raster_chk |-> vdump == exp_v
    ) else report_mismatch("vdump", 32'($sampled(vdump)), 32'($sampled(exp_v)));

    blank_rule_a: assert property (@(posedge clk) disable iff (rst)
        raster_chk |-> blankn == exp_blankn
    ) else report_mismatch("blankn", 32'($sampled(blankn)), 32'($sampled(exp_blankn)));

    pixel_a: assert property (@(posedge clk) disable iff (rst)
        (check_en && int'(hdump) >= lead_px && in_visible(hdump, vdump)) |-> pxl == exp_pxl
    ) else report_mismatch("pxl", 32'($sampled(pxl)), 32'($sampled(exp_pxl)));

    rdata_a: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && pready && !pwrite) |-> prdata == exp_rdata
    ) else report_mismatch("prdata", $sampled(prdata), $sampled(exp_rdata));

    // vram reads: low in the first access cycle, high in the second
    read_wait_a: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && !pwrite && !paddr[12] && !prev_penable) |-> !pready
    ) else report_mismatch("pready", 32'($sampled(pready)), 32'h0);

    read_second_a: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && !pwrite && !paddr[12] && prev_penable && !prev_pready) |-> pready
    ) else report_mismatch("pready", 32'($sampled(pready)), 32'h1);

    quick_ready_a: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && !prev_penable && (pwrite || paddr[12])) |-> pready
    ) else report_mismatch("pready", 32'($sampled(pready)), 32'h1);

    slverr_decode_a: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && pready) |-> pslverr == addr_unmapped(paddr)
    ) else report_mismatch("pslverr", 32'($sampled(pslverr)),
                           32'(addr_unmapped($sampled(paddr))));

    reset_ready_a: assert property (@(posedge clk) disable iff (rst)
        post_reset |-> !pready
    ) else report_mismatch("pready", 32'($sampled(pready)), 32'h0);

    reset_slverr_a: assert property (@(posedge clk) disable iff (rst)
        post_reset |-> !pslverr
    ) else report_mismatch("pslverr", 32'($sampled(pslverr)), 32'h0);

    reset_pxl_a: assert property (@(posedge clk) disable iff (rst)
        post_reset |-> pxl == '0
    ) else report_mismatch("pxl", 32'($sampled(pxl)), 32'h0);

    initial begin
        tile_pkg::tile_attr_t attr;
        int idx;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(10675));
        $readmemh("tiles.hex", rom_ref);
        repeat (8) @(negedge clk);
        rst        = 1'b0;
        post_reset = 1'b1;
        repeat (2) @(negedge clk);
        raster_chk = 1'b1;
        repeat (2) @(negedge clk);
        post_reset = 1'b0;

        fill_vram();
        repeat (8) begin
            idx         = $urandom_range(tile_pkg::vram_depth - 1, 0);
            attr        = random_attr();
            shadow[idx] = attr;
            write_word(vram_offset(idx), {18'h3ffff, attr});  // upper bits must not stick
            read_word(vram_offset(idx), tile_pkg::apb_data_t'(attr));
        end

        // unmapped write lands on vram word 1 if the decode is wrong
        write_word(tile_pkg::ctrl_addr + 13'h4, 32'hffff_ffff);
        read_word(tile_pkg::ctrl_addr, 32'h0);
        read_word(vram_offset(1), tile_pkg::apb_data_t'(shadow[1]));

        check_frame();
        write_word(tile_pkg::ctrl_addr, 32'h1);
        model_flip = 1'b1;
        read_word(tile_pkg::ctrl_addr, 32'h1);
        check_frame();

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* tile_layer.f */
design/tile_pkg.sv
design/video_timer.sv
design/apb_tile_ctrl.sv
design/tile_vram.sv
design/tile_rom.sv
design/tilemap_gen.sv
design/tile_layer.sv
dv/tb_clock.sv
dv/tile_layer_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tile_layer_tb
FILELIST  ?= tile_layer.f

OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := NO ERRORS
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) tiles.hex
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tiles.hex */
// one word per tile row, codes 0..3 of 8 rows each
// byte 3 is colour bit 3, byte 0 is colour bit 0, bit 7 of each byte is the left pixel
0F3355A1
1E66AA42
3CCC5584
7899AB08
F0336610
E166CC21
C3CD9842
879B3185
FF00F00F
01020408
10204080
AA55CC33
3C0FF0C3
12345678
9ABCDEF0
0E0D0B07
C8A4E210
6D3B1F02
00FF0F70
8001C002
55AA3366
7F3F1F0F
01800360
B4D2E1F8
4B96A5C3
D3A7B5E9
2468ACE0
13579BDF
F1E2D3C4
0C0A0906
6E5D4C3B
A0B0C0D0
